//--- logic/classifier_activity.sv
`timescale 1ns/1ps
`include "classifier_consts.svh"

module classifier_activity
  import classifier_sample_pkg::*, classifier_state_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       recv_val,
  input  magnitude_t peak,
  input  energy_t    energy,
  input  magnitude_t cutoff_mag,
  input  energy_t    cutoff_energy,
  input  logic       send_rdy,
  output logic       recv_rdy,
  output logic       advance,
  output logic       send_val,
  output logic       send_msg
);

  logic            s1_valid;    // stage 1 holds a frame
  logic            detected;
  activity_state_e state;
  activity_state_e state_next;
  frame_count_t    on_count;
  frame_count_t    on_count_next;
  frame_count_t    off_count;
  frame_count_t    off_count_next;

  // the whole pipeline stalls only when a result is waiting
  assign advance  = !send_val || send_rdy;
  assign recv_rdy = advance;

  // both thresholds must be exceeded
  assign detected = (peak > cutoff_mag) && (energy > cutoff_energy);

  always_comb begin
    state_next     = state;
    on_count_next  = on_count;
    off_count_next = off_count;
    case (state)
      act_silent: begin
        if (detected) begin
          on_count_next = on_count + 1'b1;
          if (on_count_next == frame_count_t'(`CLS_ON_FRAMES)) begin
            state_next     = act_sound;
            on_count_next  = '0;
            off_count_next = '0;
          end
        end else begin
          on_count_next = '0;   // run broken
        end
      end
      act_sound: begin
        if (!detected) begin
          off_count_next = off_count + 1'b1;
          if (off_count_next == frame_count_t'(`CLS_OFF_FRAMES)) begin
            state_next     = act_silent;
            on_count_next  = '0;
            off_count_next = '0;
          end
        end else begin
          off_count_next = '0;
        end
      end
      default: state_next = act_silent;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      send_val  <= 1'b0;
      send_msg  <= 1'b0;
      state     <= act_silent;
      on_count  <= '0;
      off_count <= '0;
    end else if (advance) begin
      s1_valid <= recv_val;     // recv_rdy equals advance here
      send_val <= s1_valid;
      if (s1_valid) begin
        // hysteresis moves only on real frames
        state     <= state_next;
        on_count  <= on_count_next;
        off_count <= off_count_next;
        send_msg  <= (state_next == act_sound);
      end
    end
  end

endmodule

//--- logic/classifier_band_config.sv
`timescale 1ns/1ps
`include "classifier_consts.svh"

module classifier_band_config import classifier_sample_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  logic       cutoff_idx_low_val,
  output logic       cutoff_idx_low_rdy,
  input  bin_idx_t   cutoff_idx_low_msg,

  input  logic       cutoff_idx_high_val,
  output logic       cutoff_idx_high_rdy,
  input  bin_idx_t   cutoff_idx_high_msg,

  input  logic       cutoff_mag_val,
  output logic       cutoff_mag_rdy,
  input  magnitude_t cutoff_mag_msg,

  input  logic       cutoff_energy_val,
  output logic       cutoff_energy_rdy,
  input  energy_t    cutoff_energy_msg,

  output magnitude_t cutoff_mag,
  output energy_t    cutoff_energy,
  output band_mask_t band_mask
);

  bin_idx_t idx_low;
  bin_idx_t idx_high;

  // config ports never stall
  assign cutoff_idx_low_rdy  = 1'b1;
  assign cutoff_idx_high_rdy = 1'b1;
  assign cutoff_mag_rdy      = 1'b1;
  assign cutoff_energy_rdy   = 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      idx_low       <= '0;
      idx_high      <= '0;   // band is bin 0 only out of reset
      cutoff_mag    <= '0;
      cutoff_energy <= '0;
    end else begin
      if (cutoff_idx_low_val)  idx_low       <= cutoff_idx_low_msg;
      if (cutoff_idx_high_val) idx_high      <= cutoff_idx_high_msg;
      if (cutoff_mag_val)      cutoff_mag    <= cutoff_mag_msg;
      if (cutoff_energy_val)   cutoff_energy <= cutoff_energy_msg;
    end
  end

  // the one place where bin indices are compared against the band edges
  for (genvar i = 0; i < `CLS_N_SAMPLES; i++) begin : g_mask
    assign band_mask[i] = (bin_idx_t'(i) >= idx_low) && (bin_idx_t'(i) <= idx_high);
  end

endmodule

//--- logic/classifier_band_energy.sv
`timescale 1ns/1ps
`include "classifier_consts.svh"

module classifier_band_energy import classifier_sample_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       advance,
  input  frame_t     frame,
  input  band_mask_t band_mask,
  output energy_t    energy
);

  energy_t    band_sum;
  magnitude_t bin_mag;

  // adder tree is left to synthesis, all terms at full energy width
  always_comb begin
    band_sum = '0;
    bin_mag  = '0;
    for (int i = 0; i < `CLS_N_SAMPLES; i++) begin
      bin_mag = frame[i*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH];
      if (band_mask[i]) begin
        band_sum = band_sum + energy_t'(bin_mag);
      end
    end
  end

  // registered alongside the peak so both land in stage 1 together
  always_ff @(posedge clk) begin
    if (reset) begin
      energy <= '0;
    end else if (advance) begin
      energy <= band_sum;
    end
  end

endmodule

//--- logic/classifier_band_peak.sv
`timescale 1ns/1ps
`include "classifier_consts.svh"

module classifier_band_peak import classifier_sample_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       advance,
  input  frame_t     frame,
  input  band_mask_t band_mask,
  output magnitude_t peak
);

  magnitude_t masked [`CLS_N_SAMPLES];
  magnitude_t run_max [`CLS_N_SAMPLES];   // run_max[i] is the max of bins 0..i

  for (genvar i = 0; i < `CLS_N_SAMPLES; i++) begin : g_bins
    // out-of-band bins count as silence
    assign masked[i] = band_mask[i] ? frame[i*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH] : '0;
  end

  assign run_max[0] = masked[0];

  for (genvar i = 1; i < `CLS_N_SAMPLES; i++) begin : g_chain
    assign run_max[i] = (masked[i] > run_max[i-1]) ? masked[i] : run_max[i-1];
  end

  // stage 1 register, holds under back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      peak <= '0;
    end else if (advance) begin
      peak <= run_max[`CLS_N_SAMPLES-1];
    end
  end

endmodule

//--- logic/classifier_consts.svh
`ifndef CLASSIFIER_CONSTS_SVH
`define CLASSIFIER_CONSTS_SVH

// frame geometry
`define CLS_MAG_WIDTH 16
`define CLS_N_SAMPLES 8
`define CLS_IDX_WIDTH 8

// 8 full-scale magnitudes need 19 bits, one spare
`define CLS_ENERGY_WIDTH 20

// hysteresis, counted in accepted frames
`define CLS_ON_FRAMES 3
`define CLS_OFF_FRAMES 5
`define CLS_COUNT_WIDTH 8

`endif

//--- logic/classifier_sample_pkg.sv
`include "classifier_consts.svh"

package classifier_sample_pkg;

  typedef logic [`CLS_MAG_WIDTH-1:0] magnitude_t;     // one spectral bin
  typedef logic [`CLS_IDX_WIDTH-1:0] bin_idx_t;
  typedef logic [`CLS_ENERGY_WIDTH-1:0] energy_t;     // in-band sum

  // one bit per bin, set when the bin lies inside the band
  typedef logic [`CLS_N_SAMPLES-1:0] band_mask_t;

  // whole frame, bin 0 in the low bits
  typedef logic [`CLS_N_SAMPLES*`CLS_MAG_WIDTH-1:0] frame_t;

endpackage

//--- logic/classifier_state_pkg.sv
`include "classifier_consts.svh"

package classifier_state_pkg;

  typedef enum logic {
    act_silent = 1'b0,
    act_sound  = 1'b1
  } activity_state_e;

  typedef logic [`CLS_COUNT_WIDTH-1:0] frame_count_t;  // run length in frames

endpackage

//--- logic/classifier_top.sv
`timescale 1ns/1ps

module classifier_top import classifier_sample_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // frames in
  input  logic       recv_val,
  output logic       recv_rdy,
  input  frame_t     recv_msg,

  // one result bit per frame out
  output logic       send_val,
  input  logic       send_rdy,
  output logic       send_msg,

  input  logic       cutoff_idx_low_val,
  output logic       cutoff_idx_low_rdy,
  input  bin_idx_t   cutoff_idx_low_msg,

  input  logic       cutoff_idx_high_val,
  output logic       cutoff_idx_high_rdy,
  input  bin_idx_t   cutoff_idx_high_msg,

  input  logic       cutoff_mag_val,
  output logic       cutoff_mag_rdy,
  input  magnitude_t cutoff_mag_msg,

  input  logic       cutoff_energy_val,
  output logic       cutoff_energy_rdy,
  input  energy_t    cutoff_energy_msg
);

  magnitude_t cutoff_mag;
  energy_t    cutoff_energy;
  band_mask_t band_mask;
  logic       advance;      // stage enable from the activity unit
  magnitude_t peak;
  energy_t    energy;

  classifier_band_config u_band_config (
    .clk                 (clk),
    .reset               (reset),
    .cutoff_idx_low_val  (cutoff_idx_low_val),
    .cutoff_idx_low_rdy  (cutoff_idx_low_rdy),
    .cutoff_idx_low_msg  (cutoff_idx_low_msg),
    .cutoff_idx_high_val (cutoff_idx_high_val),
    .cutoff_idx_high_rdy (cutoff_idx_high_rdy),
    .cutoff_idx_high_msg (cutoff_idx_high_msg),
    .cutoff_mag_val      (cutoff_mag_val),
    .cutoff_mag_rdy      (cutoff_mag_rdy),
    .cutoff_mag_msg      (cutoff_mag_msg),
    .cutoff_energy_val   (cutoff_energy_val),
    .cutoff_energy_rdy   (cutoff_energy_rdy),
    .cutoff_energy_msg   (cutoff_energy_msg),
    .cutoff_mag          (cutoff_mag),
    .cutoff_energy       (cutoff_energy),
    .band_mask           (band_mask)
  );

  // peak and energy work side by side on the same frame
  classifier_band_peak u_band_peak (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .frame     (recv_msg),
    .band_mask (band_mask),
    .peak      (peak)
  );

  classifier_band_energy u_band_energy (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .frame     (recv_msg),
    .band_mask (band_mask),
    .energy    (energy)
  );

  classifier_activity u_activity (
    .clk           (clk),
    .reset         (reset),
    .recv_val      (recv_val),
    .peak          (peak),
    .energy        (energy),
    .cutoff_mag    (cutoff_mag),
    .cutoff_energy (cutoff_energy),
    .send_rdy      (send_rdy),
    .recv_rdy      (recv_rdy),
    .advance       (advance),
    .send_val      (send_val),
    .send_msg      (send_msg)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module classifier_tb \
  -Mdir obj_dir \
  -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vclassifier_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation passed"
exit 0

//--- tests/classifier_tb.sv
`timescale 1ns/1ps
`include "classifier_consts.svh"

module classifier_tb import classifier_sample_pkg::*; ();

  localparam int STIM_CYCLES = 800;            // directed part plus 200 random frames
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

  logic clk;
  logic reset;
  logic recv_val, recv_rdy, send_val, send_rdy, send_msg;
  frame_t recv_msg;
  logic cutoff_idx_low_val, cutoff_idx_low_rdy, cutoff_idx_high_val, cutoff_idx_high_rdy;
  logic cutoff_mag_val, cutoff_mag_rdy, cutoff_energy_val, cutoff_energy_rdy;
  bin_idx_t cutoff_idx_low_msg, cutoff_idx_high_msg;
  magnitude_t cutoff_mag_msg;
  energy_t cutoff_energy_msg;
  logic cfg_rdy_all;

  integer seed = 32'h26f1;
  logic [31:0] rnd_rdy;
  logic rand_bp = 1'b0;                        // random back-pressure on send_rdy
  int cycle = 0;
  int rdy_low_edges = 0;                       // edges seen with send_rdy low

  // reference model state
  bin_idx_t m_low, m_high;
  magnitude_t m_mag;
  energy_t m_energy;
  logic recv_fire = 1'b0, recv_det = 1'b0, send_fire = 1'b0, send_bit = 1'b0;
  bit sound = 1'b0;
  int on_run = 0;
  int off_run = 0;
  bit exp_q[$];
  int acc_q[$];                                // accept cycle per frame
  int low_q[$];                                // rdy_low_edges at accept

  classifier_top UUT (.*);

  assign cfg_rdy_all = cutoff_idx_low_rdy && cutoff_idx_high_rdy &&
                       cutoff_mag_rdy && cutoff_energy_rdy;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Finished with errors");
    $fatal;
  endtask

  // detection straight from the band and threshold rules
  function automatic bit frame_detected(input frame_t f);
    magnitude_t bin;
    magnitude_t peak = '0;
    energy_t sum = '0;
    for (int i = 0; i < `CLS_N_SAMPLES; i++) begin
      bin = f[i*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH];
      if (bin_idx_t'(i) >= m_low && bin_idx_t'(i) <= m_high) begin
        if (bin > peak) peak = bin;
        sum = sum + energy_t'(bin);
      end
    end
    return (peak > m_mag) && (sum > m_energy);
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    recv_fire <= recv_val && recv_rdy && !reset;
    recv_det  <= frame_detected(recv_msg);   // config before this edge
    send_fire <= send_val && send_rdy && !reset;
    send_bit  <= send_msg;
    if (!send_rdy) rdy_low_edges <= rdy_low_edges + 1;
    if (reset) begin
      m_low <= '0;
      m_high <= '0;
      m_mag <= '0;
      m_energy <= '0;
    end else begin
      if (cutoff_idx_low_val) m_low <= cutoff_idx_low_msg;
      if (cutoff_idx_high_val) m_high <= cutoff_idx_high_msg;
      if (cutoff_mag_val) m_mag <= cutoff_mag_msg;
      if (cutoff_energy_val) m_energy <= cutoff_energy_msg;
    end
  end

  // scoreboard works on what was captured at the last rising edge
  always @(negedge clk) begin
    if (recv_fire) begin
      if (!sound) begin
        if (recv_det) begin
          on_run = on_run + 1;
          if (on_run == `CLS_ON_FRAMES) begin
            sound = 1'b1;
            on_run = 0;
            off_run = 0;
          end
        end else on_run = 0;
      end else begin
        if (!recv_det) begin
          off_run = off_run + 1;
          if (off_run == `CLS_OFF_FRAMES) begin
            sound = 1'b0;
            on_run = 0;
            off_run = 0;
          end
        end else off_run = 0;
      end
      exp_q.push_back(sound);
      acc_q.push_back(cycle);
      low_q.push_back(rdy_low_edges);
    end
    if (send_fire) begin
      assert (exp_q.size() != 0) else report_error("result sent with no frame in flight");
      assert (send_bit == exp_q[0]) else report_error("send_msg differs from the model");
      if (low_q[0] == rdy_low_edges) begin   // no stall since accept
        assert (cycle - acc_q[0] == 2) else report_error("latency is not 2 cycles");
      end
      void'(exp_q.pop_front());
      void'(acc_q.pop_front());
      void'(low_q.pop_front());
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && send_msg == $past(send_msg)))
    else report_error("send_val or send_msg changed while send_rdy was low");

  a_cfg_rdy: assert property (@(posedge clk) disable iff (reset) cfg_rdy_all)
    else report_error("a config rdy went low");

  a_no_stall: assert property (@(posedge clk) disable iff (reset) !send_val |-> recv_rdy)
    else report_error("recv_rdy low with the output empty");

  always @(negedge clk) begin
    if (rand_bp) begin
      rnd_rdy = $random(seed);
      send_rdy = rnd_rdy[0] | rnd_rdy[1];   // ready about 3 cycles in 4
    end else send_rdy = 1'b1;
  end

  always @(posedge clk) begin
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $fatal;
    end
  end

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic drive_frame(input frame_t f);
    recv_val = 1'b1;
    recv_msg = f;
    do @(negedge clk); while (!recv_fire);
    recv_val = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0 || send_val) @(negedge clk);
  endtask

  task automatic write_config(input bin_idx_t low, input bin_idx_t high,
                              input magnitude_t mag, input energy_t energy);
    wait_drain();
    cutoff_idx_low_val = 1'b1;
    cutoff_idx_low_msg = low;
    cutoff_idx_high_val = 1'b1;
    cutoff_idx_high_msg = high;
    cutoff_mag_val = 1'b1;
    cutoff_mag_msg = mag;
    cutoff_energy_val = 1'b1;
    cutoff_energy_msg = energy;
    @(negedge clk);                          // always ready, one edge is enough
    cutoff_idx_low_val = 1'b0;
    cutoff_idx_high_val = 1'b0;
    cutoff_mag_val = 1'b0;
    cutoff_energy_val = 1'b0;
  endtask

  function automatic frame_t single_bin_frame(input int bin, input magnitude_t mag);
    frame_t f = '0;
    f[bin*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH] = mag;
    return f;
  endfunction

  function automatic frame_t band_fill_frame(input int lo, input int hi, input magnitude_t mag);
    frame_t f = '0;
    for (int i = lo; i <= hi; i++) f[i*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH] = mag;
    return f;
  endfunction

  task automatic make_random_frame(output frame_t f);
    logic [31:0] rnd;
    for (int i = 0; i < `CLS_N_SAMPLES; i++) begin
      rnd = $random(seed);
      f[i*`CLS_MAG_WIDTH +: `CLS_MAG_WIDTH] = rnd[15:0];
    end
  endtask

  initial begin
    frame_t rf;
    logic [31:0] gap;
    reset = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    send_rdy = 1'b1;
    cutoff_idx_low_val = 1'b0;
    cutoff_idx_low_msg = '0;
    cutoff_idx_high_val = 1'b0;
    cutoff_idx_high_msg = '0;
    cutoff_mag_val = 1'b0;
    cutoff_mag_msg = '0;
    cutoff_energy_val = 1'b0;
    cutoff_energy_msg = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    assert (!send_val && recv_rdy && cfg_rdy_all) else report_error("wrong state after reset");

    // band 2..4, loud bin 6 is out of band, bin 3 is in band
    write_config(8'd2, 8'd4, 16'd100, 20'd100);
    repeat (3) drive_frame(single_bin_frame(6, 16'd5000));
    repeat (3) drive_frame(single_bin_frame(3, 16'd5000));
    repeat (5) drive_frame('0);

    // one threshold passes, the other fails
    write_config(8'd1, 8'd6, 16'd1000, 20'd5000);
    repeat (3) drive_frame(single_bin_frame(4, 16'd2000));   // peak only
    repeat (3) drive_frame(band_fill_frame(1, 6, 16'd999));  // energy only

    // hysteresis run lengths around both limits
    repeat (2) drive_frame(band_fill_frame(1, 6, 16'd1200));
    drive_frame('0);
    repeat (3) drive_frame(band_fill_frame(1, 6, 16'd1200));
    repeat (4) drive_frame('0);
    drive_frame(band_fill_frame(1, 6, 16'd1200));
    repeat (5) drive_frame('0);

    // random frames under random back-pressure
    write_config(8'd0, 8'd7, 16'he000, 20'h40000);
    rand_bp = 1'b1;
    for (int n = 0; n < 200; n++) begin
      make_random_frame(rf);
      gap = $random(seed);
      if (gap[1:0] == 2'b00) @(negedge clk);
      drive_frame(rf);
    end
    rand_bp = 1'b0;
    // at most two frames in flight, each out within its 2-cycle latency once send_rdy is high
    repeat (6) @(negedge clk);

    if (exp_q.size() != 0) begin
      $display("%0d expected results were never sent", exp_q.size());
      $display("Finished with errors");
      $fatal;
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+logic
logic/classifier_sample_pkg.sv
logic/classifier_state_pkg.sv
logic/classifier_band_config.sv
logic/classifier_band_peak.sv
logic/classifier_band_energy.sv
logic/classifier_activity.sv
logic/classifier_top.sv
tests/classifier_tb.sv
